//--- Core.f
design/CoreIsaPkg.sv
design/CorePipePkg.sv
design/InstrDecoder.sv
design/RegFile.sv
design/IntAlu.sv
design/Multiply.sv
design/Rob.sv
design/Core.sv
test/Core_asserts.sv
test/CoreTb.sv

//--- design/Core.sv
`timescale 1ns/10ps
`default_nettype none

module Core #(
  parameter int robDepth = 8,
  parameter int mulStages = 3
) (
  input  wire clk,
  input  wire rstN,
  input  wire CoreIsaPkg::Instr_t instr,
  input  wire instrValid,
  output logic stall,
  output logic commitValid,
  output CorePipePkg::SqN_t commitSqN,
  output logic commitWrite,
  output CoreIsaPkg::RegIdx_t commitRd,
  output CoreIsaPkg::RegT commitData
);

  CorePipePkg::IssueUOp issueUOp;
  CorePipePkg::ResultUOp aluResult;
  CorePipePkg::ResultUOp mulResult;
  CorePipePkg::CommitUOp commitUOp;
  CorePipePkg::SqN_t nextSqN;
  CoreIsaPkg::RegIdx_t rfAddrA;
  CoreIsaPkg::RegIdx_t rfAddrB;
  CoreIsaPkg::RegT rfDataA;
  CoreIsaPkg::RegT rfDataB;
  logic [CoreIsaPkg::NumRegs-1:0] pendingRegs;
  logic robFull;
  logic dispatch;

  InstrDecoder decoder (
    .clk(clk),
    .rstN(rstN),
    .instr(instr),
    .instrValid(instrValid),
    .stall(stall),
    .pendingRegs(pendingRegs),
    .robFull(robFull),
    .nextSqN(nextSqN),
    .rfAddrA(rfAddrA),
    .rfAddrB(rfAddrB),
    .rfDataA(rfDataA),
    .rfDataB(rfDataB),
    .issueUOp(issueUOp),
    .dispatch(dispatch)
  );

  RegFile regFile (
    .clk(clk),
    .rstN(rstN),
    .rAddrA(rfAddrA),
    .rAddrB(rfAddrB),
    .rDataA(rfDataA),
    .rDataB(rfDataB),
    .commitUOp(commitUOp)
  );

  IntAlu intAlu (
    .clk(clk),
    .rstN(rstN),
    .issueUOp(issueUOp),
    .resultUOp(aluResult)
  );

  Multiply #(.mulStages(mulStages)) multiply (
    .clk(clk),
    .rstN(rstN),
    .issueUOp(issueUOp),
    .resultUOp(mulResult)
  );

  Rob #(.robDepth(robDepth)) rob (
    .clk(clk),
    .rstN(rstN),
    .dispatch(dispatch),
    .issueUOp(issueUOp),
    .aluResult(aluResult),
    .mulResult(mulResult),
    .pendingRegs(pendingRegs),
    .robFull(robFull),
    .nextSqN(nextSqN),
    .commitUOp(commitUOp)
  );

  assign commitValid = commitUOp.valid;
  assign commitSqN = commitUOp.sqN;
  assign commitWrite = commitUOp.writes;
  assign commitRd = commitUOp.rd;
  assign commitData = commitUOp.value;

endmodule

`default_nettype wire

//--- design/CoreIsaPkg.sv
`default_nettype none

package CoreIsaPkg;

  localparam int NumRegs = 8;
  localparam int ImmBits = 6;

  typedef logic [$clog2(NumRegs)-1:0] RegIdx_t;
  typedef logic [15:0] RegT;

  // Codes 8 to 15 are undefined and decode as no-ops.
  typedef enum logic [3:0] {
    OpNop  = 4'h0,
    OpAdd  = 4'h1,
    OpSub  = 4'h2,
    OpAnd  = 4'h3,
    OpOr   = 4'h4,
    OpXor  = 4'h5,
    OpAddi = 4'h6,
    OpMul  = 4'h7
  } Opcode_t;

  typedef struct packed {
    Opcode_t opcode;
    RegIdx_t rd;
    RegIdx_t rs1;
    RegIdx_t rs2;    // Upper half of the immediate for OpAddi.
    logic [2:0] spare;
  } Instr_t;

endpackage

`default_nettype wire

//--- design/CorePipePkg.sv
`default_nettype none

package CorePipePkg;

  typedef logic [7:0] SqN_t; // Wraps, compare by difference only.

  typedef enum logic [1:0] {
    FuNone = 2'd0,
    FuAlu  = 2'd1,
    FuMul  = 2'd2
  } FuncUnit_t;

  typedef struct packed {
    logic valid;
    SqN_t sqN;
    CoreIsaPkg::Opcode_t opcode;
    FuncUnit_t fu;
    CoreIsaPkg::RegIdx_t rd;
    logic writes;
    CoreIsaPkg::RegT opA;
    CoreIsaPkg::RegT opB;         // Holds the sign-extended immediate for OpAddi.
  } IssueUOp;

  typedef struct packed {
    logic valid;
    SqN_t sqN;
    CoreIsaPkg::RegT result;
  } ResultUOp;

  typedef struct packed {
    logic valid;
    SqN_t sqN;
    logic writes;
    CoreIsaPkg::RegIdx_t rd;
    CoreIsaPkg::RegT value;
  } CommitUOp;

endpackage

`default_nettype wire

//--- design/InstrDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module InstrDecoder (
  input  wire clk,
  input  wire rstN,
  input  wire CoreIsaPkg::Instr_t instr,
  input  wire instrValid,
  output logic stall,
  input  wire [CoreIsaPkg::NumRegs-1:0] pendingRegs,
  input  wire robFull,
  input  wire CorePipePkg::SqN_t nextSqN,
  output CoreIsaPkg::RegIdx_t rfAddrA,
  output CoreIsaPkg::RegIdx_t rfAddrB,
  input  wire CoreIsaPkg::RegT rfDataA,
  input  wire CoreIsaPkg::RegT rfDataB,
  output CorePipePkg::IssueUOp issueUOp,
  output logic dispatch
);

  logic decValid;
  CoreIsaPkg::Instr_t decInstr;
  logic useA;
  logic useB;
  logic hazard;
  CorePipePkg::FuncUnit_t fu;
  logic [CoreIsaPkg::ImmBits-1:0] imm;
  CoreIsaPkg::RegT immExt;

  always_comb begin
    useA = 1'b0;
    useB = 1'b0;
    fu = CorePipePkg::FuNone;
    case (decInstr.opcode)
      CoreIsaPkg::OpAdd, CoreIsaPkg::OpSub, CoreIsaPkg::OpAnd,
      CoreIsaPkg::OpOr, CoreIsaPkg::OpXor: begin
        useA = 1'b1;
        useB = 1'b1;
        fu = CorePipePkg::FuAlu;
      end
      CoreIsaPkg::OpAddi: begin
        useA = 1'b1;
        fu = CorePipePkg::FuAlu;
      end
      CoreIsaPkg::OpMul: begin
        useA = 1'b1;
        useB = 1'b1;
        fu = CorePipePkg::FuMul;
      end
      default: ; // Nop and undefined codes read nothing.
    endcase
  end

  // r0 never has a pending writer.
  assign hazard = (useA && decInstr.rs1 != '0 && pendingRegs[decInstr.rs1])
               || (useB && decInstr.rs2 != '0 && pendingRegs[decInstr.rs2]);
  assign dispatch = decValid && !hazard && !robFull;
  assign stall = decValid && !dispatch;

  assign imm = decInstr[CoreIsaPkg::ImmBits-1:0];
  assign immExt = {{($bits(CoreIsaPkg::RegT) - CoreIsaPkg::ImmBits){imm[CoreIsaPkg::ImmBits-1]}},
                   imm};

  assign rfAddrA = decInstr.rs1;
  assign rfAddrB = decInstr.rs2;

  always_comb begin
    issueUOp.valid = dispatch;
    issueUOp.sqN = nextSqN;
    issueUOp.opcode = decInstr.opcode;
    issueUOp.fu = fu;
    issueUOp.rd = decInstr.rd;
    issueUOp.writes = (fu != CorePipePkg::FuNone) && (decInstr.rd != '0);
    issueUOp.opA = rfDataA;
    issueUOp.opB = (decInstr.opcode == CoreIsaPkg::OpAddi) ? immExt : rfDataB;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      decValid <= 1'b0;
    end else if (!stall) begin
      decValid <= instrValid; // Refill as the held uop leaves.
    end
  end

  always_ff @(posedge clk) begin
    if (!stall && instrValid) begin
      decInstr <= instr;
    end
  end

endmodule

`default_nettype wire

//--- design/IntAlu.sv
`timescale 1ns/10ps
`default_nettype none

module IntAlu (
  input  wire clk,
  input  wire rstN,
  input  wire CorePipePkg::IssueUOp issueUOp,
  output CorePipePkg::ResultUOp resultUOp
);

  CoreIsaPkg::RegT aluOut;
  logic take;

  assign take = issueUOp.valid && (issueUOp.fu == CorePipePkg::FuAlu);

  always_comb begin
    case (issueUOp.opcode)
      CoreIsaPkg::OpAdd, CoreIsaPkg::OpAddi: aluOut = issueUOp.opA + issueUOp.opB;
      CoreIsaPkg::OpSub: aluOut = issueUOp.opA - issueUOp.opB;
      CoreIsaPkg::OpAnd: aluOut = issueUOp.opA & issueUOp.opB;
      CoreIsaPkg::OpOr:  aluOut = issueUOp.opA | issueUOp.opB;
      CoreIsaPkg::OpXor: aluOut = issueUOp.opA ^ issueUOp.opB;
      default: aluOut = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resultUOp <= '0;
    end else begin
      resultUOp <= '{valid: take, sqN: issueUOp.sqN, result: aluOut};
    end
  end

endmodule

`default_nettype wire

//--- design/Multiply.sv
`timescale 1ns/10ps
`default_nettype none

module Multiply #(
  parameter int mulStages = 3
) (
  input  wire clk,
  input  wire rstN,
  input  wire CorePipePkg::IssueUOp issueUOp,
  output CorePipePkg::ResultUOp resultUOp
);

  logic [mulStages-1:0] validPipe;
  CorePipePkg::SqN_t sqNPipe [mulStages];
  CoreIsaPkg::RegT prodPipe [mulStages];
  logic [2*$bits(CoreIsaPkg::RegT)-1:0] fullProd;
  logic take;

  assign take = issueUOp.valid && (issueUOp.fu == CorePipePkg::FuMul);
  assign fullProd = issueUOp.opA * issueUOp.opB;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validPipe <= '0;
    end else begin
      validPipe[0] <= take;
      for (int i = 1; i < mulStages; i++) begin
        validPipe[i] <= validPipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    sqNPipe[0] <= issueUOp.sqN;
    prodPipe[0] <= fullProd[$bits(CoreIsaPkg::RegT)-1:0]; // Low half only.
    for (int i = 1; i < mulStages; i++) begin
      sqNPipe[i] <= sqNPipe[i-1];
      prodPipe[i] <= prodPipe[i-1];
    end
  end

  always_comb begin
    resultUOp.valid = validPipe[mulStages-1];
    resultUOp.sqN = sqNPipe[mulStages-1];
    resultUOp.result = prodPipe[mulStages-1];
  end

endmodule

`default_nettype wire

//--- design/RegFile.sv
`timescale 1ns/10ps
`default_nettype none

module RegFile (
  input  wire clk,
  input  wire rstN,
  input  wire CoreIsaPkg::RegIdx_t rAddrA,
  input  wire CoreIsaPkg::RegIdx_t rAddrB,
  output CoreIsaPkg::RegT rDataA,
  output CoreIsaPkg::RegT rDataB,
  input  wire CorePipePkg::CommitUOp commitUOp
);

  CoreIsaPkg::RegT regs [CoreIsaPkg::NumRegs];
  logic writeEn;

  assign writeEn = commitUOp.valid && commitUOp.writes && (commitUOp.rd != '0);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < CoreIsaPkg::NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[commitUOp.rd] <= commitUOp.value;
    end
  end

  // r0 is hardwired to zero.
  assign rDataA = (rAddrA == '0) ? '0 : regs[rAddrA];
  assign rDataB = (rAddrB == '0) ? '0 : regs[rAddrB];

endmodule

`default_nettype wire

//--- design/Rob.sv
`timescale 1ns/10ps
`default_nettype none

module Rob #(
  parameter int robDepth = 8
) (
  input  wire clk,
  input  wire rstN,
  input  wire dispatch,
  input  wire CorePipePkg::IssueUOp issueUOp,
  input  wire CorePipePkg::ResultUOp aluResult,
  input  wire CorePipePkg::ResultUOp mulResult,
  output logic [CoreIsaPkg::NumRegs-1:0] pendingRegs,
  output logic robFull,
  output CorePipePkg::SqN_t nextSqN,
  output CorePipePkg::CommitUOp commitUOp
);

  localparam int IdxBits = $clog2(robDepth);

  logic [robDepth-1:0] entryDone;
  logic [robDepth-1:0] entryWrites;
  CoreIsaPkg::RegIdx_t entryRd [robDepth];
  CoreIsaPkg::RegT entryValue [robDepth];
  CorePipePkg::SqN_t lastWriter [CoreIsaPkg::NumRegs];

  CorePipePkg::SqN_t headSqN;
  CorePipePkg::SqN_t tailSqN;
  logic [IdxBits-1:0] headIdx;
  logic [IdxBits-1:0] tailIdx;
  logic headReady;
  logic retireReg;

  assign headIdx = headSqN[IdxBits-1:0];
  assign tailIdx = tailSqN[IdxBits-1:0];
  assign nextSqN = tailSqN;
  assign robFull = (CorePipePkg::SqN_t'(tailSqN - headSqN) == CorePipePkg::SqN_t'(robDepth));
  assign headReady = (headSqN != tailSqN) && entryDone[headIdx];

  // Released when the register file takes the write, one cycle after commit.
  assign retireReg = commitUOp.valid && commitUOp.writes
                  && (lastWriter[commitUOp.rd] == commitUOp.sqN);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      headSqN <= '0;
      tailSqN <= '0;
      entryDone <= '0;
      pendingRegs <= '0;
      commitUOp <= '0;
    end else begin
      commitUOp <= '{valid: headReady, sqN: headSqN, writes: entryWrites[headIdx],
                     rd: entryRd[headIdx], value: entryValue[headIdx]};
      if (headReady) begin
        entryDone[headIdx] <= 1'b0;
        headSqN <= headSqN + 1'b1;
      end
      if (aluResult.valid) begin
        entryDone[aluResult.sqN[IdxBits-1:0]] <= 1'b1;
      end
      if (mulResult.valid) begin
        entryDone[mulResult.sqN[IdxBits-1:0]] <= 1'b1;
      end
      if (retireReg) begin
        pendingRegs[commitUOp.rd] <= 1'b0;
      end
      if (dispatch) begin
        entryDone[tailIdx] <= (issueUOp.fu == CorePipePkg::FuNone); // No unit to wait on.
        tailSqN <= tailSqN + 1'b1;
        if (issueUOp.writes) begin
          pendingRegs[issueUOp.rd] <= 1'b1; // A new writer overrides the release.
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dispatch) begin
      entryWrites[tailIdx] <= issueUOp.writes;
      entryRd[tailIdx] <= issueUOp.rd;
      entryValue[tailIdx] <= '0;
      if (issueUOp.writes) begin
        lastWriter[issueUOp.rd] <= issueUOp.sqN;
      end
    end
    if (aluResult.valid) begin
      entryValue[aluResult.sqN[IdxBits-1:0]] <= aluResult.result;
    end
    if (mulResult.valid) begin
      entryValue[mulResult.sqN[IdxBits-1:0]] <= mulResult.result;
    end
  end

endmodule

`default_nettype wire

//--- test/CoreTb.sv
`timescale 1ns/10ps
`default_nettype none

module CoreTb;

  localparam int MaxInstrs = 120;
  localparam int CyclesPerInstr = 20;
  localparam int TimeoutCycles = MaxInstrs * CyclesPerInstr + 600;

  logic clk;
  logic rstN;
  CoreIsaPkg::Instr_t instr;
  logic instrValid;
  logic stall;
  logic commitValid;
  CorePipePkg::SqN_t commitSqN;
  logic commitWrite;
  CoreIsaPkg::RegIdx_t commitRd;
  CoreIsaPkg::RegT commitData;

  CoreIsaPkg::RegT shadowRegs [CoreIsaPkg::NumRegs];
  CorePipePkg::CommitUOp expQ [$];
  CorePipePkg::SqN_t expSqN;
  int errorCount;
  int stallCycles;
  int pushCount;
  int commitCount;
  int testsRun;
  int testsFailed;
  int cycleCount;
  int startErrors;
  int startPushes;
  int startCommits;

  Core #(.robDepth(8), .mulStages(3)) Core_inst (
    .clk(clk),
    .rstN(rstN),
    .instr(instr),
    .instrValid(instrValid),
    .stall(stall),
    .commitValid(commitValid),
    .commitSqN(commitSqN),
    .commitWrite(commitWrite),
    .commitRd(commitRd),
    .commitData(commitData)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("Some tests failed");
    $finish;
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
      errorCount++;
    end
  endtask

  function automatic int errorsSoFar();
    return errorCount + Core_inst.coreAsserts.assertFails;
  endfunction

  function automatic CoreIsaPkg::Instr_t makeInstr(input logic [3:0] op, input logic [2:0] rd,
                                                   input logic [2:0] rs1, input logic [2:0] rs2);
    return CoreIsaPkg::Instr_t'({op, rd, rs1, rs2, 3'b000});
  endfunction

  function automatic CoreIsaPkg::Instr_t makeAddi(input logic [2:0] rd, input logic [2:0] rs1,
                                                  input logic [5:0] imm);
    return CoreIsaPkg::Instr_t'({4'(CoreIsaPkg::OpAddi), rd, rs1, imm});
  endfunction

  // Reference model, applied in program order.
  task automatic expectInstr(input CoreIsaPkg::Instr_t ins);
    CoreIsaPkg::RegT a;
    CoreIsaPkg::RegT b;
    CoreIsaPkg::RegT imm;
    CoreIsaPkg::RegT value;
    logic defined;
    CorePipePkg::CommitUOp exp;
    a = shadowRegs[ins.rs1];
    b = shadowRegs[ins.rs2];
    imm = {{10{ins[5]}}, ins[5:0]};
    defined = 1'b1;
    case (ins[15:12])
      CoreIsaPkg::OpAdd: value = a + b;
      CoreIsaPkg::OpSub: value = a - b;
      CoreIsaPkg::OpAnd: value = a & b;
      CoreIsaPkg::OpOr: value = a | b;
      CoreIsaPkg::OpXor: value = a ^ b;
      CoreIsaPkg::OpAddi: value = a + imm;
      CoreIsaPkg::OpMul: value = a * b; // Low 16 bits of the product.
      default: begin
        defined = 1'b0;
        value = '0;
      end
    endcase
    exp.valid = 1'b1;
    exp.sqN = expSqN;
    exp.writes = defined && (ins.rd != 3'd0);
    exp.rd = ins.rd;
    exp.value = exp.writes ? value : '0;
    if (exp.writes) begin
      shadowRegs[ins.rd] = value;
    end
    expQ.push_back(exp);
    expSqN++;
  endtask

  // Called 5 ns after a rising edge; returns 5 ns after the accepting edge.
  task automatic pushInstr(input CoreIsaPkg::Instr_t ins);
    expectInstr(ins);
    pushCount++;
    instr = ins;
    instrValid = 1'b1;
    @(negedge clk);
    while (stall) begin
      stallCycles++;
      @(negedge clk);
    end
    @(posedge clk);
    #5;
    instrValid = 1'b0;
  endtask

  always @(negedge clk) begin
    CorePipePkg::CommitUOp exp;
    if (rstN && commitValid) begin
      commitCount++;
      if (expQ.size() == 0) begin
        $display("Error at %0d ns: commit of sequence number %0d with no instruction outstanding",
                 $time, commitSqN);
        errorCount++;
      end else begin
        exp = expQ.pop_front();
        checkValue("commitSqN", commitSqN, exp.sqN);
        checkValue("commitWrite", commitWrite, exp.writes);
        checkValue("commitRd", commitRd, exp.rd);
        if (exp.writes) begin
          checkValue("commitData", commitData, exp.value);
        end
      end
    end
  end

  task automatic finishTest(input string name);
    int errs;
    while (expQ.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk); // Catch duplicate commits.
    #5;
    checkValue("commit count", commitCount - startCommits, pushCount - startPushes);
    errs = errorsSoFar() - startErrors;
    testsRun++;
    if (errs == 0) begin
      $display("Test %s: passed", name);
    end else begin
      testsFailed++;
      $display("Test %s: failed with %0d errors", name, errs);
    end
    startErrors = errorsSoFar();
    startPushes = pushCount;
    startCommits = commitCount;
    stallCycles = 0;
  endtask

  task automatic testReset();
    repeat (4) begin
      @(negedge clk);
      checkValue("stall", stall, 0);
      checkValue("commitValid", commitValid, 0);
    end
    @(posedge clk);
    #5;
    finishTest("reset");
  endtask

  task automatic testAluOps();
    pushInstr(makeAddi(3'd1, 3'd0, 6'd13));
    pushInstr(makeAddi(3'd2, 3'd0, 6'h39)); // -7.
    pushInstr(makeAddi(3'd3, 3'd0, 6'd31));
    pushInstr(makeAddi(3'd4, 3'd0, 6'h20)); // -32.
    pushInstr(makeInstr(CoreIsaPkg::OpAdd, 3'd5, 3'd1, 3'd2));
    pushInstr(makeInstr(CoreIsaPkg::OpSub, 3'd6, 3'd2, 3'd3));
    pushInstr(makeInstr(CoreIsaPkg::OpAnd, 3'd7, 3'd3, 3'd4));
    pushInstr(makeInstr(CoreIsaPkg::OpOr, 3'd5, 3'd1, 3'd4));
    pushInstr(makeInstr(CoreIsaPkg::OpXor, 3'd6, 3'd2, 3'd1));
    finishTest("ALU operations");
  endtask

  task automatic testChain();
    logic [2:0] src;
    logic [2:0] dst;
    pushInstr(makeAddi(3'd1, 3'd0, 6'd3));
    for (int i = 0; i < 8; i++) begin
      src = (i % 2 == 0) ? 3'd1 : 3'd2;
      dst = (i % 2 == 0) ? 3'd2 : 3'd1;
      if (i % 3 == 1) begin
        pushInstr(makeAddi(dst, src, 6'd5));
      end else if (i % 3 == 2) begin
        pushInstr(makeInstr(CoreIsaPkg::OpMul, dst, src, src));
      end else begin
        pushInstr(makeInstr(CoreIsaPkg::OpAdd, dst, src, src));
      end
    end
    if (stallCycles == 0) begin
      $display("Error: the dependency chain never raised stall");
      errorCount++;
    end
    finishTest("dependency chain");
  endtask

  task automatic testOutOfOrder();
    pushInstr(makeAddi(3'd1, 3'd0, 6'd12));
    pushInstr(makeAddi(3'd2, 3'd0, 6'h3d)); // -3.
    pushInstr(makeInstr(CoreIsaPkg::OpMul, 3'd3, 3'd1, 3'd2));
    pushInstr(makeInstr(CoreIsaPkg::OpAdd, 3'd4, 3'd1, 3'd1));
    pushInstr(makeInstr(CoreIsaPkg::OpAdd, 3'd5, 3'd2, 3'd2));
    pushInstr(makeInstr(CoreIsaPkg::OpXor, 3'd6, 3'd1, 3'd2));
    pushInstr(makeInstr(CoreIsaPkg::OpMul, 3'd7, 3'd5, 3'd6));
    pushInstr(makeInstr(CoreIsaPkg::OpSub, 3'd4, 3'd2, 3'd1));
    finishTest("out-of-order completion");
  endtask

  task automatic testBackPressure();
    logic [3:0] op;
    logic [2:0] rd;
    logic [2:0] rs1;
    logic [2:0] rs2;
    for (int i = 0; i < 40; i++) begin
      if (($urandom % 4) != 0) begin
        op = CoreIsaPkg::OpMul;
      end else begin
        op = 4'($urandom % 6 + 1);
      end
      rd = 3'($urandom % 8);
      rs1 = 3'($urandom % 8);
      rs2 = 3'($urandom % 8);
      if (op == CoreIsaPkg::OpAddi) begin
        pushInstr(makeAddi(rd, rs1, 6'($urandom % 64)));
      end else begin
        pushInstr(makeInstr(op, rd, rs1, rs2));
      end
    end
    finishTest("back-pressure");
  endtask

  task automatic testZeroAndNop();
    pushInstr(makeAddi(3'd1, 3'd0, 6'd9));
    pushInstr(makeAddi(3'd0, 3'd1, 6'd9));
    pushInstr(makeInstr(CoreIsaPkg::OpAdd, 3'd0, 3'd1, 3'd1));
    pushInstr(makeInstr(CoreIsaPkg::OpMul, 3'd0, 3'd1, 3'd1));
    pushInstr(makeInstr(CoreIsaPkg::OpNop, 3'd3, 3'd1, 3'd1));
    pushInstr(makeInstr(4'h9, 3'd4, 3'd1, 3'd1));
    pushInstr(makeInstr(4'hf, 3'd5, 3'd2, 3'd1));
    pushInstr(makeInstr(CoreIsaPkg::OpAdd, 3'd6, 3'd0, 3'd0));
    pushInstr(makeInstr(CoreIsaPkg::OpOr, 3'd7, 3'd0, 3'd3));
    pushInstr(makeInstr(CoreIsaPkg::OpAdd, 3'd2, 3'd4, 3'd5));
    finishTest("r0, no-op and undefined opcodes");
  endtask

  initial begin
    rstN = 1'b0;
    instr = '0;
    instrValid = 1'b0;
    void'($urandom(6));
    expSqN = '0;
    errorCount = 0;
    stallCycles = 0;
    pushCount = 0;
    commitCount = 0;
    testsRun = 0;
    testsFailed = 0;
    startErrors = 0;
    startPushes = 0;
    startCommits = 0;
    for (int i = 0; i < CoreIsaPkg::NumRegs; i++) begin
      shadowRegs[i] = '0;
    end
    repeat (2) @(posedge clk);
    #5;
    rstN = 1'b1;
    testReset();
    testAluOps();
    testChain();
    testOutOfOrder();
    testBackPressure();
    testZeroAndNop();
    $display("Summary: %0d tests run, %0d passed, %0d failed, %0d errors",
             testsRun, testsRun - testsFailed, testsFailed, errorsSoFar());
    if (errorsSoFar() == 0 && testsFailed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/Core_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module CoreAsserts (
  input wire clk,
  input wire rstN,
  input wire stall,
  input wire commitValid,
  input wire CorePipePkg::SqN_t commitSqN,
  input wire commitWrite,
  input wire CoreIsaPkg::RegIdx_t commitRd
);

  int assertFails = 0; // Read by the testbench at the end of the run.
  logic haveLast;
  CorePipePkg::SqN_t lastSqN;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      haveLast <= 1'b0;
      lastSqN <= '0;
    end else if (commitValid) begin
      haveLast <= 1'b1;
      lastSqN <= commitSqN;
    end
  end

  resetQuiet: assert property (@(posedge clk) $rose(rstN) |-> !stall && !commitValid)
    else begin
      $error("stall or commitValid is high in the first cycle after reset");
      assertFails++;
    end

  sqNStep: assert property (@(posedge clk) disable iff (!rstN)
    commitValid && haveLast |-> commitSqN == CorePipePkg::SqN_t'(lastSqN + 1'b1))
    else begin
      $error("commitSqN did not advance by one from the previous commit");
      assertFails++;
    end

  noWriteToR0: assert property (@(posedge clk) disable iff (!rstN)
    commitValid |-> !(commitWrite && commitRd == '0))
    else begin
      $error("commitWrite is high for a commit to r0");
      assertFails++;
    end

endmodule

bind Core CoreAsserts coreAsserts (
  .clk(clk),
  .rstN(rstN),
  .stall(stall),
  .commitValid(commitValid),
  .commitSqN(commitSqN),
  .commitWrite(commitWrite),
  .commitRd(commitRd)
);

`default_nettype wire
